//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_accel_cr
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- accel_cr_defines.svh
`ifndef ACCEL_CR_DEFINES_SVH
`define ACCEL_CR_DEFINES_SVH

// ==========================================================================
// Bus widths
// ==========================================================================
`define CR_DATA_W 32
`define CR_ADDR_W 32

// ==========================================================================
// Register map, byte offsets
// ==========================================================================
`define CR_SEG7_0_OFF 32'h0000_0000
`define CR_SEG7_1_OFF 32'h0000_0004
`define CR_SEG7_2_OFF 32'h0000_0008
`define CR_SEG7_3_OFF 32'h0000_000C
`define CR_SEG7_4_OFF 32'h0000_0010
`define CR_SEG7_5_OFF 32'h0000_0014
`define CR_LED_OFF    32'h0000_0018

// Register file shape
`define CR_NUM_REGS   7
`define CR_NUM_DIGITS 6
`define CR_DIGIT_W    8
`define CR_LED_W      10
`define CR_SEG_W      7

`endif

//--- accel_cr_mem.sv
`timescale 1ns/1ps
`include "accel_cr_defines.svh"

module accel_cr_mem (
    input  logic                   clk,
    input  logic                   arst_n,
    // Core port
    input  cr_bus_pkg::cr_access_t cr_acc,
    output logic [`CR_DATA_W-1:0]  q,
    // Fabric port, read only
    input  logic [`CR_ADDR_W-1:0]  address_b,
    output logic [`CR_DATA_W-1:0]  q_b
);
    import cr_bus_pkg::*;
    import cr_map_pkg::*;

    cr_regs_t regs;

    // ======================================================================
    // Read decode shared by both ports
    // ======================================================================

    // Zero-extended register value, zero for unmapped offsets
    function automatic logic [`CR_DATA_W-1:0] read_word(
        input logic [`CR_ADDR_W-1:0] offset,
        input cr_regs_t              r
    );
        logic [`CR_DATA_W-1:0] word;
        word = '0;
        case (offset)
            `CR_SEG7_0_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[0];
            `CR_SEG7_1_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[1];
            `CR_SEG7_2_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[2];
            `CR_SEG7_3_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[3];
            `CR_SEG7_4_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[4];
            `CR_SEG7_5_OFF: word[`CR_DIGIT_W-1:0] = r.seg7[5];
            `CR_LED_OFF:    word[`CR_LED_W-1:0]   = r.led;
            default:        word = '0;
        endcase
        return word;
    endfunction

    // ======================================================================
    // Register writes
    // ======================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else if (cr_acc.wren) begin
            // Only the low bits of each word are kept
            case (cr_acc.address)
                `CR_SEG7_0_OFF: regs.seg7[0] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_SEG7_1_OFF: regs.seg7[1] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_SEG7_2_OFF: regs.seg7[2] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_SEG7_3_OFF: regs.seg7[3] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_SEG7_4_OFF: regs.seg7[4] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_SEG7_5_OFF: regs.seg7[5] <= cr_acc.data[`CR_DIGIT_W-1:0];
                `CR_LED_OFF:    regs.led     <= cr_acc.data[`CR_LED_W-1:0];
                default: begin
                    // Unmapped, nothing changes
                    regs <= regs;
                end
            endcase
        end
    end

    // ======================================================================
    // Registered read ports
    // ======================================================================

    // Core read, loaded on the rden strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (cr_acc.rden) begin
            q <= read_word(cr_acc.address, regs);
        end
    end

    // Fabric read, sampled every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_b <= '0;
        end else begin
            q_b <= read_word(address_b, regs);
        end
    end

endmodule

//--- accel_cr_top.sv
`timescale 1ns/1ps
`include "accel_cr_defines.svh"

module accel_cr_top (
    input  logic                  clk,
    input  logic                  arst_n,
    // Processor bus
    input  cr_bus_pkg::apb_req_t  apb_req,
    output cr_bus_pkg::apb_rsp_t  apb_rsp,
    // Board pins
    output cr_map_pkg::seg7_out_t disp
);
    import cr_bus_pkg::*;

    // ======================================================================
    // Internal wiring
    // ======================================================================

    cr_access_t            cr_acc;
    logic [`CR_DATA_W-1:0] q;
    logic [`CR_ADDR_W-1:0] address_b;
    logic [`CR_DATA_W-1:0] q_b;

    // APB to register strobes
    apb_cr_bridge u_bridge (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cr_acc  (cr_acc),
        .q       (q)
    );

    // Register file with core and fabric ports
    accel_cr_mem u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .cr_acc    (cr_acc),
        .q         (q),
        .address_b (address_b),
        .q_b       (q_b)
    );

    // Fabric port walker and segment decode
    seg7_display_scanner u_scan (
        .clk       (clk),
        .arst_n    (arst_n),
        .address_b (address_b),
        .q_b       (q_b),
        .disp      (disp)
    );

endmodule

//--- apb_cr_bridge.sv
`timescale 1ns/1ps
`include "accel_cr_defines.svh"

module apb_cr_bridge (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cr_bus_pkg::apb_req_t   apb_req,
    output cr_bus_pkg::apb_rsp_t   apb_rsp,
    output cr_bus_pkg::cr_access_t cr_acc,
    input  logic [`CR_DATA_W-1:0]  q
);
    import cr_bus_pkg::*;

    // ======================================================================
    // Access phase sequencer
    // ======================================================================

    // IDLE covers setup and the first access cycle, WAIT is the ready cycle
    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t state;
    logic   access_start;
    logic   is_write;

    // First cycle of the access phase
    assign access_start = apb_req.psel && apb_req.penable && (state == ST_IDLE);
    assign is_write     = apb_req.pwrite;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (access_start) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Register strobes
    // ======================================================================

    always_comb begin
        cr_acc.wren    = access_start && is_write;
        cr_acc.rden    = access_start && !is_write;
        // Byte address down to a word-aligned offset
        cr_acc.address = {apb_req.paddr[`CR_ADDR_W-1:2], 2'b00};
        cr_acc.data    = apb_req.pwdata;
    end

    // ======================================================================
    // APB response
    // ======================================================================

    always_comb begin
        apb_rsp.pready = (state == ST_WAIT);
        // q holds the word fetched by last cycle's rden
        if (apb_rsp.pready && !is_write) begin
            apb_rsp.prdata = q;
        end else begin
            apb_rsp.prdata = '0;
        end
    end

endmodule

//--- cr_bus_pkg.sv
`include "accel_cr_defines.svh"

package cr_bus_pkg;

    // ======================================================================
    // APB side
    // ======================================================================

    // Request from the processor, held through the access phase
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`CR_ADDR_W-1:0] paddr;
        logic [`CR_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Response back to the processor
    typedef struct packed {
        logic                  pready;
        logic [`CR_DATA_W-1:0] prdata;
    } apb_rsp_t;

    // ======================================================================
    // Core side register access
    // ======================================================================

    // Strobes last a single cycle; address is a word-aligned byte offset
    typedef struct packed {
        logic                  wren;
        logic                  rden;
        logic [`CR_ADDR_W-1:0] address;
        logic [`CR_DATA_W-1:0] data;
    } cr_access_t;

endpackage

//--- cr_map_pkg.sv
`include "accel_cr_defines.svh"

package cr_map_pkg;

    // ======================================================================
    // Register file contents
    // ======================================================================

    // Digit values, index 0 sits at offset 0x00
    typedef logic [`CR_NUM_DIGITS-1:0][`CR_DIGIT_W-1:0] seg7_vals_t;

    typedef struct packed {
        seg7_vals_t            seg7;
        logic [`CR_LED_W-1:0]  led;
    } cr_regs_t;

    // ======================================================================
    // Board display outputs
    // ======================================================================

    // One active-low segment field per digit, bit order {g,f,e,d,c,b,a}
    typedef logic [`CR_NUM_DIGITS-1:0][`CR_SEG_W-1:0] seg7_pins_t;

    typedef struct packed {
        seg7_pins_t            hex;
        logic [`CR_LED_W-1:0]  led;
    } seg7_out_t;

    // Segments lit for digit value 0
    localparam logic [`CR_SEG_W-1:0] SEG7_DIGIT_0 = 7'h40;

    // Display state right after reset, all registers read as zero
    localparam seg7_out_t DISP_RESET = '{
        hex: {`CR_NUM_DIGITS{SEG7_DIGIT_0}},
        led: '0
    };

endpackage

//--- seg7_display_scanner.sv
`timescale 1ns/1ps
`include "accel_cr_defines.svh"

module seg7_display_scanner (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic [`CR_ADDR_W-1:0] address_b,
    input  logic [`CR_DATA_W-1:0] q_b,
    output cr_map_pkg::seg7_out_t disp
);
    import cr_map_pkg::*;

    localparam int IDX_W = $clog2(`CR_NUM_REGS);

    logic [IDX_W-1:0] scan_idx;
    logic [IDX_W-1:0] scan_idx_d;

    // Active-low hex font, bit order {g,f,e,d,c,b,a}
    function automatic logic [`CR_SEG_W-1:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    // ======================================================================
    // Scan counter
    // ======================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_idx   <= '0;
            scan_idx_d <= '0;
        end else begin
            if (scan_idx == IDX_W'(`CR_NUM_REGS - 1)) begin
                scan_idx <= '0;
            end else begin
                scan_idx <= scan_idx + 1'b1;
            end
            // Tags the word coming back on q_b
            scan_idx_d <= scan_idx;
        end
    end

    // Registers are one word apart
    assign address_b = `CR_SEG7_0_OFF + {scan_idx, 2'b00};

    // ======================================================================
    // Output latches
    // ======================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp <= DISP_RESET;
        end else if (scan_idx_d < IDX_W'(`CR_NUM_DIGITS)) begin
            // Digit shows the low nibble only
            disp.hex[scan_idx_d] <= hex_to_seg(q_b[3:0]);
        end else begin
            disp.led <= q_b[`CR_LED_W-1:0];
        end
    end

endmodule

//--- tb.f
+incdir+.
cr_bus_pkg.sv
cr_map_pkg.sv
apb_cr_bridge.sv
accel_cr_mem.sv
seg7_display_scanner.sv
accel_cr_top.sv
tb_accel_cr.sv

//--- tb_accel_cr.sv
`timescale 1ns/1ps
`include "accel_cr_defines.svh"

module tb_accel_cr;
    import cr_bus_pkg::*;
    import cr_map_pkg::*;

    // ======================================================================
    // Run length
    // ======================================================================

    // Setup, two access cycles, one idle cycle
    localparam int XFER_CYC    = 4;
    localparam int DISP_WAIT   = 12;
    localparam int N_MAPPED    = 40;
    localparam int N_UNMAPPED  = 20;
    localparam int N_MIXED     = 300;
    localparam int N_XFERS     = 2 * `CR_NUM_REGS + 2 * N_MAPPED + 2 * N_UNMAPPED + N_MIXED;
    localparam int N_DISP      = N_MAPPED + N_UNMAPPED + 1;
    localparam int CYCLE_LIMIT = 4 + XFER_CYC * N_XFERS + (DISP_WAIT + 1) * N_DISP + 200;

    logic      clk;
    logic      arst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    seg7_out_t disp;

    cr_regs_t  model;
    integer    seed;
    int        cycle_cnt;
    int        errors;
    int        checks;

    accel_cr_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .disp    (disp)
    );

    always #50 clk = ~clk;

    // Ends a run that stops making progress
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    // Lit segments {g,f,e,d,c,b,a} for each hex digit
    function automatic logic [6:0] font_lit(input logic [3:0] nibble);
        logic [6:0] lit [16];
        lit = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return lit[nibble];
    endfunction

    // Register number for a byte address or -1 when unmapped
    function automatic int reg_index(input logic [31:0] addr);
        if (addr[1:0] == 2'b00 && addr <= 32'h18) begin
            return int'(addr >> 2);
        end
        return -1;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        int          idx;
        logic [31:0] word;
        idx  = reg_index(addr);
        word = '0;
        if (idx >= 0 && idx < `CR_NUM_DIGITS) begin
            word[7:0] = model.seg7[idx];
        end else if (idx == `CR_NUM_DIGITS) begin
            word[9:0] = model.led;
        end
        return word;
    endfunction

    // Truncation keeps 8 bits per digit and 10 for the LEDs
    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        int idx;
        idx = reg_index(addr);
        if (idx >= 0 && idx < `CR_NUM_DIGITS) begin
            model.seg7[idx] = data[7:0];
        end else if (idx == `CR_NUM_DIGITS) begin
            model.led = data[9:0];
        end
    endtask

    function automatic logic [31:0] rand_mapped_addr();
        return ({$random(seed)} % `CR_NUM_REGS) * 4;
    endfunction

    function automatic logic [31:0] rand_unmapped_addr();
        logic [31:0] addr;
        addr = $random(seed) & 32'hFFFF_FFFC;
        while (addr <= 32'h18) begin
            addr = $random(seed) & 32'hFFFF_FFFC;
        end
        return addr;
    endfunction

    // ======================================================================
    // Checks and bus access
    // ======================================================================

    task automatic check_value(input logic [63:0] expected, input logic [63:0] actual,
                               input string what);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0t: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
        end
    endtask

    // One APB transfer sampled at the falling edge
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int cyc;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        cyc = 1;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        cyc = 2;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(posedge clk);
            cyc++;
            @(negedge clk);
        end
        check_value(3, cyc, $sformatf("pready cycle for address 0x%08h", addr));
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
        model_write(addr, data);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] rdata;
        apb_transfer(1'b0, addr, '0, rdata);
        check_value(model_read(addr), rdata, $sformatf("read of 0x%08h", addr));
    endtask

    task automatic check_display();
        logic [6:0] exp_seg;
        for (int i = 0; i < `CR_NUM_DIGITS; i++) begin
            // Active low on the pins
            exp_seg = ~font_lit(model.seg7[i][3:0]);
            check_value(exp_seg, disp.hex[i], $sformatf("digit %0d segments", i));
        end
        check_value(model.led, disp.led, "LED outputs");
    endtask

    task automatic wait_display();
        repeat (DISP_WAIT) @(posedge clk);
        @(negedge clk);
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        int          kind;
        logic [31:0] addr;
        clk       = 1'b0;
        arst_n    = 1'b0;
        apb_req   = '0;
        model     = '0;
        seed      = 32'ha7e24e6d;
        cycle_cnt = 0;
        errors    = 0;
        checks    = 0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_display();
        for (int i = 0; i < `CR_NUM_REGS; i++) begin
            read_check(i * 4);
        end

        // Mapped writes with read back
        for (int n = 0; n < N_MAPPED; n++) begin
            addr = rand_mapped_addr();
            write_reg(addr, $random(seed));
            wait_display();
            check_display();
            read_check(addr);
        end

        // Unmapped writes leave everything alone
        for (int n = 0; n < N_UNMAPPED; n++) begin
            addr = rand_unmapped_addr();
            write_reg(addr, $random(seed));
            wait_display();
            check_display();
            read_check(rand_unmapped_addr());
        end

        // Random mix of reads and writes
        for (int n = 0; n < N_MIXED; n++) begin
            kind = {$random(seed)} % 4;
            case (kind)
                0: write_reg(rand_mapped_addr(), $random(seed));
                1: read_check(rand_mapped_addr());
                2: write_reg(rand_unmapped_addr(), $random(seed));
                default: read_check(rand_unmapped_addr());
            endcase
        end
        wait_display();
        check_display();
        for (int i = 0; i < `CR_NUM_REGS; i++) begin
            read_check(i * 4);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
